// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // basic widths
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;
    localparam int BLOCK_W = 64;   // two instructions per block

    typedef logic [ADDR_W-1:0]  addr_t;   // byte address
    typedef logic [INSTR_W-1:0] instr_t;  // one instruction word
    typedef logic [BLOCK_W-1:0] block_t;  // cache block, low half at pc[2] == 0

    // major opcodes seen by the predecoder
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq, bne, blt, ...
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // pc after reset
    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

// ==== src/pc_gen.sv ====
`timescale 1ns/100ps

module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stall,              // miss or queue full
    input  logic  recovery_pc_valid,  // one-cycle redirect from backend
    input  addr_t recovery_pc,
    input  addr_t next_pc,            // predicted, from predecode
    output addr_t pc
);

    addr_t pc_mux;  // value loaded on the next edge

    // recovery beats stall, stall beats prediction
    always_comb begin
        if (recovery_pc_valid) begin
            pc_mux = recovery_pc;
        end else if (stall) begin
            pc_mux = pc;  // hold
        end else begin
            pc_mux = next_pc;
        end
    end

    // fetch pc register, written every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_mux;
        end
    end

endmodule

// ==== src/icache.sv ====
`timescale 1ns/100ps

module icache import fetch_pkg::*; #(
    parameter int NUM_SETS = 16   // power of two
) (
    input  logic   clk,
    input  logic   arst_n,
    input  addr_t  pc,              // registered fetch pc
    input  logic   mem_resp_valid,  // single-cycle fill pulse
    input  addr_t  mem_resp_addr,
    input  block_t mem_resp_data,
    output logic   hit,
    output instr_t instr,           // half of the block picked by pc[2]
    output logic   mem_req_valid,   // level, high while pc misses
    output addr_t  mem_req_addr     // block aligned
);

    // address split: | tag | index | offset(3) |
    localparam int OFS_W = 3;
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFS_W - IDX_W;

    logic [NUM_SETS-1:0] valid_q;          // per-set valid bits
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    block_t              data_mem [NUM_SETS];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    block_t           rd_block;

    // lookup side, from pc
    assign rd_idx = pc[OFS_W +: IDX_W];
    assign rd_tag = pc[ADDR_W-1 -: TAG_W];

    // fill side, from the memory response address
    assign wr_idx = mem_resp_addr[OFS_W +: IDX_W];
    assign wr_tag = mem_resp_addr[ADDR_W-1 -: TAG_W];

    // combinational hit check on the stored arrays only,
    // so a fill shows up as a hit on the following cycle
    assign rd_block = data_mem[rd_idx];
    assign hit      = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    // instruction select within the block
    always_comb begin
        if (pc[2]) begin
            instr = rd_block[BLOCK_W-1:INSTR_W];  // upper word
        end else begin
            instr = rd_block[INSTR_W-1:0];
        end
    end

    // refill request
    assign mem_req_valid = ~hit;
    assign mem_req_addr  = {pc[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

    // valid bits, the only state that needs clearing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (mem_resp_valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (mem_resp_valid) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= mem_resp_data;  // whole block at once
        end
    end

endmodule

// ==== src/predecode.sv ====
`timescale 1ns/100ps

module predecode import fetch_pkg::*; (
    input  addr_t  pc,
    input  instr_t instr,
    output addr_t  next_pc,        // predicted next fetch pc
    output logic   is_cond_br,
    output logic   br_taken_pred
);

    logic [6:0] opcode;
    logic       is_jal;
    addr_t      imm_b;   // sign-extended B-type offset
    addr_t      imm_j;   // sign-extended J-type offset
    logic       br_back; // backward branch

    assign opcode = instr[6:0];

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    assign is_cond_br = (opcode == OPC_BRANCH);
    assign is_jal     = (opcode == OPC_JAL);
    assign br_back    = imm_b[ADDR_W-1];  // negative offset

    // static prediction: btfn for branches, jal always taken
    assign br_taken_pred = is_jal | (is_cond_br & br_back);

    always_comb begin
        if (is_jal) begin
            next_pc = pc + imm_j;
        end else if (is_cond_br && br_back) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc + 32'd4;  // fall through
        end
    end

endmodule

// ==== src/instr_queue.sv ====
`timescale 1ns/100ps

module instr_queue import fetch_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,           // drops all entries, wins over enqueue
    input  logic   enq_valid,       // already qualified with not full
    input  instr_t enq_instr,
    input  addr_t  enq_pc,
    input  addr_t  enq_next_pc,
    input  logic   enq_is_cond_br,
    input  logic   enq_taken,
    output logic   full,            // registered
    input  logic   deq_ready,
    output logic   deq_valid,
    output instr_t deq_instr,
    output addr_t  deq_pc,
    output addr_t  deq_next_pc,
    output logic   deq_is_cond_br,
    output logic   deq_taken
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // entry storage, no reset needed on payload
    instr_t instr_q   [QUEUE_DEPTH];
    addr_t  pc_q      [QUEUE_DEPTH];
    addr_t  next_pc_q [QUEUE_DEPTH];
    logic   cond_q    [QUEUE_DEPTH];
    logic   taken_q   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count, count_nxt;
    logic             do_enq, do_deq;

    assign deq_valid = (count != '0);        // independent of ready
    assign do_deq    = deq_valid & deq_ready;
    assign do_enq    = enq_valid & ~flush;   // nothing enters on a flush

    always_comb begin
        count_nxt = count;
        if (do_enq && !do_deq) count_nxt = count + 1'b1;
        else if (do_deq && !do_enq) count_nxt = count - 1'b1;
    end

    // head entry straight from storage
    assign deq_instr      = instr_q[rd_ptr];
    assign deq_pc         = pc_q[rd_ptr];
    assign deq_next_pc    = next_pc_q[rd_ptr];
    assign deq_is_cond_br = cond_q[rd_ptr];
    assign deq_taken      = taken_q[rd_ptr];

    // pointers, count and full flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
        end else begin
            if (do_enq) wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_deq) rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_nxt;
            full  <= (count_nxt == CNT_W'(QUEUE_DEPTH));
        end
    end

    // payload write
    always_ff @(posedge clk) begin
        if (do_enq) begin
            instr_q[wr_ptr]   <= enq_instr;
            pc_q[wr_ptr]      <= enq_pc;
            next_pc_q[wr_ptr] <= enq_next_pc;
            cond_q[wr_ptr]    <= enq_is_cond_br;
            taken_q[wr_ptr]   <= enq_taken;
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; #(
    parameter int NUM_SETS    = 16,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic   clk,
    input  logic   arst_n,
    // backend redirect
    input  logic   recovery_pc_valid,
    input  addr_t  recovery_pc,
    // main memory
    output logic   mem_req_valid,
    output addr_t  mem_req_addr,
    input  logic   mem_resp_valid,
    input  addr_t  mem_resp_addr,
    input  block_t mem_resp_data,
    // to dispatch
    input  logic   dispatch_ready,
    output logic   dispatch_valid,
    output instr_t dispatch_instr,
    output addr_t  dispatch_pc,
    output addr_t  dispatch_next_pc,
    output logic   dispatch_is_cond_br,
    output logic   dispatch_taken
);

    addr_t  pc;
    addr_t  next_pc;
    instr_t instr;
    logic   hit;
    logic   is_cond_br;
    logic   br_taken_pred;
    logic   q_full;
    logic   stall;
    logic   enq_valid;

    assign stall     = ~hit | q_full;  // miss or no room
    assign enq_valid = hit & ~q_full;

    pc_gen u_pc_gen (
        .clk               (clk),
        .arst_n            (arst_n),
        .stall             (stall),
        .recovery_pc_valid (recovery_pc_valid),
        .recovery_pc       (recovery_pc),
        .next_pc           (next_pc),
        .pc                (pc)
    );

    icache #(.NUM_SETS(NUM_SETS)) u_icache (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_data  (mem_resp_data),
        .hit            (hit),
        .instr          (instr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr)
    );

    predecode u_predecode (
        .pc            (pc),
        .instr         (instr),
        .next_pc       (next_pc),
        .is_cond_br    (is_cond_br),
        .br_taken_pred (br_taken_pred)
    );

    // recovery also flushes the queue
    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_instr_queue (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (recovery_pc_valid),
        .enq_valid      (enq_valid),
        .enq_instr      (instr),
        .enq_pc         (pc),
        .enq_next_pc    (next_pc),
        .enq_is_cond_br (is_cond_br),
        .enq_taken      (br_taken_pred),
        .full           (q_full),
        .deq_ready      (dispatch_ready),
        .deq_valid      (dispatch_valid),
        .deq_instr      (dispatch_instr),
        .deq_pc         (dispatch_pc),
        .deq_next_pc    (dispatch_next_pc),
        .deq_is_cond_br (dispatch_is_cond_br),
        .deq_taken      (dispatch_taken)
    );

endmodule

// ==== test/fetch_unit_sva.sv ====
`timescale 1ns/100ps

module fetch_unit_sva import fetch_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input logic   recovery_pc_valid,
    input logic   mem_req_valid,
    input addr_t  mem_req_addr,
    input logic   mem_resp_valid,
    input addr_t  mem_resp_addr,
    input logic   dispatch_ready,
    input logic   dispatch_valid,
    input instr_t dispatch_instr,
    input addr_t  dispatch_pc,
    input addr_t  dispatch_next_pc,
    input logic   dispatch_is_cond_br,
    input logic   dispatch_taken,
    input addr_t  pc               // internal fetch pc
);

    // head entry held until taken, unless flushed
    assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_valid && !dispatch_ready && !recovery_pc_valid |=>
        $stable({dispatch_valid, dispatch_instr, dispatch_pc, dispatch_next_pc,
                 dispatch_is_cond_br, dispatch_taken}))
        else $error("dispatch entry changed while waiting for ready");

    // flush leaves nothing behind
    assert property (@(posedge clk) disable iff (!arst_n)
        recovery_pc_valid |=> !dispatch_valid)
        else $error("dispatch_valid high right after a recovery");

    // fill of the missing block ends the miss
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp_valid && mem_resp_addr == mem_req_addr && !recovery_pc_valid |=>
        !mem_req_valid)
        else $error("refill request still high after its block was filled");

    // miss stalls the pc
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !recovery_pc_valid |=> $stable(pc))
        else $error("pc moved during a miss");

endmodule

bind fetch_unit fetch_unit_sva u_fetch_unit_sva (.*);

// ==== test/fetch_unit_tb.sv ====
`timescale 1ns/100ps

module fetch_unit_tb import fetch_pkg::*; ();

    localparam int NUM_SETS     = 16;
    localparam int QUEUE_DEPTH  = 8;
    localparam int IDX_W        = $clog2(NUM_SETS);
    localparam int N_ENTRIES    = 600;  // three stream tests of 200
    localparam int WATCHDOG_CYC = N_ENTRIES * (6 + QUEUE_DEPTH + 10) + 20;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   recovery_pc_valid, mem_req_valid, mem_resp_valid;
    addr_t  recovery_pc, mem_req_addr, mem_resp_addr;
    block_t mem_resp_data;
    logic   dispatch_ready, dispatch_valid, dispatch_is_cond_br, dispatch_taken;
    instr_t dispatch_instr;
    addr_t  dispatch_pc, dispatch_next_pc;

    integer seed;
    int     errors, reuse_errs, got, total, refills, recoveries;
    int     wait_cnt;     // responder countdown, 0 when idle
    int     until_rec;    // cycles to next recovery pulse
    int     ready_pct;
    bit     recover_on;
    addr_t  exp_pc;       // model fetch stream

    block_t mem [addr_t];   // keyed by block address
    int     kind [addr_t];  // per word, 0 plain, 1 cond branch, 2 jal
    int     ofs [addr_t];   // byte offset of branch or jal
    bit     exp_v [NUM_SETS];
    addr_t  exp_blk [NUM_SETS];  // block held per set, from the fill rule

    fetch_unit #(.NUM_SETS(NUM_SETS), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (.*);

    always #5 clk = ~clk;

    // random word, one in four turned into a branch or jal
    function automatic instr_t gen_word(addr_t a);
        instr_t      w;
        int          k;
        logic [20:0] off;
        w = $random(seed);
        k = 0;
        kind[a] = 0;
        if (w[6:0] == OPC_BRANCH || w[6:0] == OPC_JAL) w[4] = 1'b1;  // plain stays plain
        if ({$random(seed)} % 4 == 0) begin
            k = ({$random(seed)} % 8 + 1) * 4;  // 1..8 words
            if ($random(seed) & 1) begin
                if ($random(seed) & 1) k = -k;
                off = k;
                w = {off[12], off[10:5], w[24:12], off[4:1], off[11], OPC_BRANCH};
                kind[a] = 1;
            end else begin
                if ({$random(seed)} % 4 == 0) k = -k;  // jal mostly forward
                off = k;
                w = {off[20], off[10:1], off[11], off[19:12], w[11:7], OPC_JAL};
                kind[a] = 2;
            end
        end
        ofs[a] = k;
        return w;
    endfunction

    // filled on first use
    function automatic block_t get_block(addr_t a);
        addr_t b;
        b = {a[31:3], 3'b000};
        if (!mem.exists(b)) mem[b] = {gen_word(b + 32'd4), gen_word(b)};
        return mem[b];
    endfunction

    task automatic compare_field(string name, logic [31:0] got_v, logic [31:0] exp_v_);
        assert (got_v === exp_v_) else begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got_v, exp_v_);
            errors++;
        end
    endtask

    // one dispatched entry against the predecode rule
    task automatic check_entry();
        block_t blk;
        instr_t w;
        logic   tk;
        addr_t  nxt;
        blk = get_block(exp_pc);
        w   = exp_pc[2] ? blk[63:32] : blk[31:0];
        tk  = (kind[exp_pc] == 2) || (kind[exp_pc] == 1 && ofs[exp_pc] < 0);  // btfn, jal
        nxt = tk ? exp_pc + ofs[exp_pc] : exp_pc + 32'd4;
        compare_field("dispatch_pc", dispatch_pc, exp_pc);
        compare_field("dispatch_instr", dispatch_instr, w);
        compare_field("dispatch_is_cond_br", dispatch_is_cond_br, kind[exp_pc] == 1);
        compare_field("dispatch_taken", dispatch_taken, tk);
        compare_field("dispatch_next_pc", dispatch_next_pc, nxt);
        exp_pc = nxt;
    endtask

    // one clock, all inputs changed on the falling edge
    task automatic run_cycle();
        int s;
        @(negedge clk);
        recovery_pc_valid = 1'b0;
        if (mem_resp_valid) begin  // fill taken on the last rising edge
            s = mem_resp_addr[3 +: IDX_W];
            exp_v[s]   = 1'b1;
            exp_blk[s] = mem_resp_addr;
            mem_resp_valid = 1'b0;
        end
        s = mem_req_addr[3 +: IDX_W];
        assert (!(mem_req_valid && exp_v[s] && exp_blk[s] == mem_req_addr)) else begin
            $display("t=%0t refill requested for block %h which set %0d already holds",
                     $time, mem_req_addr, s);
            errors++;
            reuse_errs++;
        end
        if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0 && mem_req_valid) begin  // answer only a live request
                mem_resp_valid = 1'b1;
                mem_resp_addr  = mem_req_addr;
                mem_resp_data  = get_block(mem_req_addr);
                refills++;
            end
        end else if (mem_req_valid) begin
            wait_cnt = 2 + {$random(seed)} % 5;  // 2..6 cycles
        end
        if (recover_on) until_rec--;
        if (recover_on && until_rec <= 0) begin
            until_rec = 20 + {$random(seed)} % 21;  // about every 30 cycles
            recovery_pc_valid = 1'b1;
            recovery_pc = {$random(seed)} & 32'h0000_fffc;
            recoveries++;
        end
        // no dispatch on the flush edge
        dispatch_ready = !recovery_pc_valid && ({$random(seed)} % 100 < ready_pct);
        if (dispatch_valid && dispatch_ready) begin
            check_entry();
            got++;
            total++;
        end
        if (recovery_pc_valid) exp_pc = recovery_pc;
    endtask

    task automatic report(string name, int e0);
        if (errors == e0) $display("%-16s pass", name);
        else $display("%-16s fail, %0d errors", name, errors - e0);
    endtask

    task automatic run_stream(string name, int n, int pct, bit rec);
        int e0;
        e0 = errors;
        got = 0;
        ready_pct = pct;
        recover_on = rec;
        until_rec = 30;
        while (got < n) run_cycle();
        report(name, e0);
    endtask

    initial begin
        int e0;
        seed = 18;
        {errors, reuse_errs, got, total, refills, recoveries, wait_cnt} = '0;
        exp_pc = RESET_PC;
        arst_n = 1'b0;
        recovery_pc_valid = 1'b0;
        recovery_pc = '0;
        mem_resp_valid = 1'b0;
        mem_resp_addr = '0;
        mem_resp_data = '0;
        dispatch_ready = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        e0 = errors;
        compare_field("dispatch_valid", dispatch_valid, 1'b0);
        compare_field("mem_req_valid", mem_req_valid, 1'b1);
        compare_field("mem_req_addr", mem_req_addr, RESET_PC);
        report("reset", e0);
        run_stream("stream", 200, 100, 1'b0);
        run_stream("back-pressure", 200, 50, 1'b0);
        run_stream("recovery", 200, 100, 1'b1);
        report("cache reuse", errors - reuse_errs);
        $display("%0d entries, %0d refills, %0d recoveries, %0d errors",
                 total, refills, recoveries, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYC * 10);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
src/fetch_pkg.sv
src/pc_gen.sv
src/icache.sv
src/predecode.sv
src/instr_queue.sv
src/fetch_unit.sv
test/fetch_unit_sva.sv
test/fetch_unit_tb.sv
